//--- Bender.yml
package:
  name: cpu

export_include_dirs:
  - include

sources:
  - verilog/cpu_pkg.sv
  - verilog/instr_decoder.sv
  - verilog/sequencer.sv
  - verilog/alu.sv
  - verilog/datapath.sv
  - verilog/cpu_top.sv
  - target: test
    files:
      - tb/cpu_sva.sv
      - tb/cpu_tb.sv

//--- include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Bit positions in the status register P
`define STATUS_C 0
`define STATUS_Z 1
`define STATUS_I 2
`define STATUS_D 3
`define STATUS_B 4
`define STATUS_R 5
`define STATUS_V 6
`define STATUS_N 7

// Address of the low byte of the reset vector
`define RESET_VECTOR 16'hFFFC

// Stack pointer after reset
`define SP_RESET 8'hFF

`endif

//--- tb/cpu_sva.sv
`timescale 1ns/100ps

module cpu_sva import cpu_pkg::*; (
	input logic       sys,
	input logic       rst_n_i,
	input logic       bus_we_i,
	input logic       pc_load_i,
	input logic       sync_i,
	input seq_state_e state_i
);

	// Set by any failing assertion
	logic fail_seen = 1'b0;

	// A store never coincides with a jump
	store_not_jump: assert property (@(posedge sys) disable iff (!rst_n_i)
		!(bus_we_i && pc_load_i))
		else begin
			fail_seen = 1'b1;
			$error("bus_we and pc_load asserted in the same cycle");
		end

	fetch_then_decode: assert property (@(posedge sys) disable iff (!rst_n_i)
		(state_i == Fetch) |=> (state_i == Decode))
		else begin
			fail_seen = 1'b1;
			$error("Fetch not followed by Decode");
		end

	// Longest instruction takes four cycles
	sync_recurs: assert property (@(posedge sys) disable iff (!rst_n_i)
		sync_i |-> ##[1:4] sync_i)
		else begin
			fail_seen = 1'b1;
			$error("sync_o absent for more than four cycles");
		end

endmodule

bind sequencer cpu_sva cpu_sva_i (
	.sys       (sys),
	.rst_n_i   (rst_n_i),
	.bus_we_i  (bus_we_o),
	.pc_load_i (pc_load_o),
	.sync_i    (sync_o),
	.state_i   (state_q)
);

//--- tb/cpu_tb.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpu_tb;

	logic        sys;
	logic        rst_n_i;
	logic [15:0] mem_addr;
	logic [7:0]  mem_rdata;
	logic [7:0]  mem_wdata;
	logic        mem_we;
	logic        sync;
	logic [7:0]  mem [0:65535];

	// Program builder and reference model state
	logic [15:0] pc_w;
	logic [15:0] out_w;
	logic [7:0]  m_a, m_x, m_y, m_sp, m_p;
	logic [15:0] exp_pc[$];
	int          exp_cycles[$];
	logic [23:0] exp_wr[$];
	logic [23:0] got_wr[$];

	cpu_top cpu_top_i (
		.sys         (sys),
		.rst_n_i     (rst_n_i),
		.mem_addr_o  (mem_addr),
		.mem_rdata_i (mem_rdata),
		.mem_wdata_o (mem_wdata),
		.mem_we_o    (mem_we),
		.sync_o      (sync)
	);

	assign mem_rdata = mem[mem_addr];

	always @(posedge sys) begin
		if (mem_we) begin
			mem[mem_addr] <= mem_wdata;
		end
	end

	// Writes are recorded mid-cycle
	always @(negedge sys) begin
		if (rst_n_i && mem_we) begin
			got_wr.push_back({mem_addr, mem_wdata});
		end
	end

	always @(negedge sys) begin
		if (cpu_top_i.sequencer_i.cpu_sva_i.fail_seen) begin
			abort_run("A sequencer assertion failed");
		end
	end

	initial begin
		sys = 1'b0;
		forever #2 sys = ~sys;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input logic [31:0] exp, input logic [31:0] act,
		input string msg);
		if (exp !== act) begin
			abort_run($sformatf("ERR %0t: %s, expected %0h, got %0h",
				$time, msg, exp, act));
		end
	endtask

	task automatic fill_memory();
		for (int i = 0; i < 65536; i++) begin
			mem[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
		end
	endtask

	function automatic logic [7:0] update_nz(input logic [7:0] r);
		m_p[`STATUS_N] = r[7];
		m_p[`STATUS_Z] = (r == 8'h00);
		return r;
	endfunction

	// SBC is ADC of the inverted operand
	task automatic model_adc(input logic [7:0] b);
		logic [8:0] s;
		s = {1'b0, m_a} + {1'b0, b} + {8'h00, m_p[`STATUS_C]};
		m_p[`STATUS_V] = (m_a[7] == b[7]) && (s[7] != m_a[7]);
		m_p[`STATUS_C] = s[8];
		m_a = update_nz(s[7:0]);
	endtask

	// Bit 8 is the bit shifted out
	task automatic model_shift(input logic [8:0] s);
		m_p[`STATUS_C] = s[8];
		m_a = update_nz(s[7:0]);
	endtask

	task automatic model_step(input logic [7:0] opc, input logic [7:0] v,
		input logic [15:0] addr);
		case (opc)
		8'h69, 8'h6D: model_adc(v);
		8'hE9, 8'hED: model_adc(~v);
		8'h29, 8'h2D: m_a = update_nz(m_a & v);
		8'h09, 8'h0D: m_a = update_nz(m_a | v);
		8'h49, 8'h4D: m_a = update_nz(m_a ^ v);
		8'hA9, 8'hAD: m_a = update_nz(v);
		8'hA2, 8'hAE: m_x = update_nz(v);
		8'hA0, 8'hAC: m_y = update_nz(v);
		8'h8D: exp_wr.push_back({addr, m_a});
		8'h8E: exp_wr.push_back({addr, m_x});
		8'h8C: exp_wr.push_back({addr, m_y});
		8'h0A: model_shift({m_a, 1'b0});
		8'h4A: model_shift({m_a[0], 1'b0, m_a[7:1]});
		8'h2A: model_shift({m_a, m_p[`STATUS_C]});
		8'h6A: model_shift({m_a[0], m_p[`STATUS_C], m_a[7:1]});
		8'hE8: m_x = update_nz(m_x + 8'd1);
		8'hC8: m_y = update_nz(m_y + 8'd1);
		8'hCA: m_x = update_nz(m_x - 8'd1);
		8'h88: m_y = update_nz(m_y - 8'd1);
		8'h38: m_p[`STATUS_C] = 1'b1;
		8'hF8: m_p[`STATUS_D] = 1'b1;
		8'h78: m_p[`STATUS_I] = 1'b1;
		8'h18: m_p[`STATUS_C] = 1'b0;
		8'hD8: m_p[`STATUS_D] = 1'b0;
		8'h58: m_p[`STATUS_I] = 1'b0;
		8'hB8: m_p[`STATUS_V] = 1'b0;
		8'hAA: m_x = update_nz(m_a);
		8'hA8: m_y = update_nz(m_a);
		8'hBA: m_x = update_nz(m_sp);
		8'h8A: m_a = update_nz(m_x);
		8'h9A: m_sp = m_x;
		8'h98: m_a = update_nz(m_y);
		default: ;
		endcase
	endtask

	task automatic emit(input logic [7:0] b);
		mem[pc_w] = b;
		pc_w = pc_w + 16'd1;
	endtask

	task automatic op_imp(input logic [7:0] opc);
		exp_pc.push_back(pc_w);
		exp_cycles.push_back(2);
		emit(opc);
		model_step(opc, 8'h00, 16'h0000);
	endtask

	task automatic op_imm(input logic [7:0] opc, input logic [7:0] v);
		exp_pc.push_back(pc_w);
		exp_cycles.push_back(2);
		emit(opc);
		emit(v);
		model_step(opc, v, 16'h0000);
	endtask

	task automatic op_abs(input logic [7:0] opc, input logic [15:0] addr);
		exp_pc.push_back(pc_w);
		emit(opc);
		emit(addr[7:0]);
		emit(addr[15:8]);
		if (opc == 8'h4C) begin
			exp_cycles.push_back(3);
			pc_w = addr;
		end else begin
			exp_cycles.push_back(4);
			model_step(opc, mem[addr], addr);
		end
	endtask

	task automatic store(input logic [7:0] opc);
		op_abs(opc, out_w);
		out_w = out_w + 16'd1;
	endtask

	// Jump to itself, so the core idles after the program
	task automatic halt();
		logic [15:0] here;
		here = pc_w;
		exp_pc.push_back(here);
		emit(8'h4C);
		emit(here[7:0]);
		emit(here[15:8]);
	endtask

	task automatic begin_program();
		@(negedge sys);
		rst_n_i = 1'b0;
		fill_memory();
		mem[`RESET_VECTOR] = 8'h00;
		mem[`RESET_VECTOR + 16'd1] = 8'h02;
		pc_w = 16'h0200;
		out_w = 16'h0600;
		m_a = 8'h00;
		m_x = 8'h00;
		m_y = 8'h00;
		m_sp = `SP_RESET;
		m_p = 8'h00;
		m_p[`STATUS_I] = 1'b1;
		m_p[`STATUS_R] = 1'b1;
		exp_pc.delete();
		exp_cycles.delete();
		exp_wr.delete();
	endtask

	task automatic wait_sync(output int cycles);
		cycles = 0;
		do begin
			@(negedge sys);
			cycles++;
			if (cycles > 16) begin
				abort_run($sformatf("Timeout: sync_o did not rise within 16 cycles at %0t",
					$time));
			end
		end while (!sync);
	endtask

	task automatic run_program();
		int cycles;
		halt();
		got_wr.delete();
		repeat (2) begin
			@(negedge sys);
			check_value(0, {mem_we, sync}, "mem_we_o and sync_o during reset");
		end
		rst_n_i = 1'b1;
		for (int i = 0; i < exp_pc.size(); i++) begin
			wait_sync(cycles);
			// JumpL and JumpH come before the first fetch
			if (i > 0) begin
				check_value(exp_cycles[i - 1], cycles,
					$sformatf("cycles of instruction %0d", i - 1));
			end else begin
				check_value(2, cycles, "cycles from reset release to first fetch");
			end
			check_value(exp_pc[i], mem_addr, $sformatf("fetch address at sync %0d", i));
		end
		check_value(exp_wr.size(), got_wr.size(), "number of memory writes");
		foreach (exp_wr[i]) begin
			check_value(exp_wr[i], got_wr[i], $sformatf("write %0d as {addr, data}", i));
		end
	endtask

	task automatic test_reset_jump();
		begin_program();
		op_abs(8'h4C, 16'h0340);
		op_imm(8'hA9, 8'h5A);
		store(8'h8D);
		op_abs(8'h4C, 16'h0280);
		op_imm(8'hA2, 8'h11);
		store(8'h8E);
		run_program();
	endtask

	task automatic test_load_store();
		begin_program();
		mem[16'h0700] = 8'hC3;
		mem[16'h0701] = 8'h7E;
		mem[16'h0702] = 8'h00;
		op_imm(8'hA9, 8'h5A);
		store(8'h8D);
		op_imm(8'hA2, 8'h81);
		store(8'h8E);
		op_imm(8'hA0, 8'h00);
		store(8'h8C);
		op_abs(8'hAD, 16'h0700);
		op_abs(8'hAE, 16'h0701);
		op_abs(8'hAC, 16'h0702);
		store(8'h8D);
		store(8'h8E);
		store(8'h8C);
		run_program();
	endtask

	task automatic test_add_sub();
		logic [7:0] a, b;
		begin_program();
		for (int i = 0; i < 3; i++) begin
			// First pair is fixed so that one sum carries
			a = (i == 0) ? 8'hF0 : 8'($urandom());
			b = (i == 0) ? 8'h20 : 8'($urandom());
			mem[16'h0700 + i] = b;
			op_imp(i[0] ? 8'h38 : 8'h18);
			op_imm(8'hA9, a);
			op_imm(8'h69, b);
			store(8'h8D);
			op_imm(8'hA9, 8'h00);
			op_imm(8'h69, 8'h00);
			store(8'h8D);
			op_imp(i[0] ? 8'h18 : 8'h38);
			op_imm(8'hA9, a);
			op_abs(8'hED, 16'h0700 + i);
			store(8'h8D);
			op_imm(8'hE9, b);
			store(8'h8D);
			op_imm(8'hA9, a);
			op_abs(8'h6D, 16'h0700 + i);
			store(8'h8D);
		end
		run_program();
	endtask

	task automatic test_logic_shift();
		logic [7:0] a, b;
		begin_program();
		for (int i = 0; i < 2; i++) begin
			a = 8'($urandom());
			b = 8'($urandom());
			mem[16'h0710 + i] = b;
			op_imm(8'hA9, a);
			op_imm(8'h29, b);
			store(8'h8D);
			op_imm(8'hA9, a);
			op_imm(8'h09, b);
			store(8'h8D);
			op_imm(8'hA9, a);
			op_abs(8'h4D, 16'h0710 + i);
			store(8'h8D);
			op_imp(i[0] ? 8'h38 : 8'h18);
			op_imm(8'hA9, a);
			op_imp(8'h2A);
			store(8'h8D);
			op_imp(8'h6A);
			store(8'h8D);
			op_imp(8'h0A);
			store(8'h8D);
			op_imp(8'h4A);
			store(8'h8D);
		end
		run_program();
	endtask

	task automatic test_transfer_count();
		begin_program();
		op_imm(8'hA2, 8'hFF);
		op_imp(8'hE8);
		store(8'h8E);
		op_imp(8'hCA);
		store(8'h8E);
		op_imm(8'hA0, 8'h00);
		op_imp(8'h88);
		store(8'h8C);
		op_imp(8'hC8);
		store(8'h8C);
		op_imm(8'hA9, 8'($urandom()));
		op_imp(8'hAA);
		store(8'h8E);
		op_imp(8'hA8);
		store(8'h8C);
		op_imm(8'hA2, 8'($urandom()));
		op_imp(8'h8A);
		store(8'h8D);
		op_imm(8'hA0, 8'($urandom()));
		op_imp(8'h98);
		store(8'h8D);
		op_imp(8'hBA);
		store(8'h8E);
		op_imm(8'hA2, 8'h3C);
		op_imp(8'h9A);
		op_imm(8'hA2, 8'h00);
		op_imp(8'hBA);
		store(8'h8E);
		run_program();
	endtask

	// No stores, so no write may appear
	task automatic test_cycle_count();
		begin_program();
		mem[16'h0720] = 8'h99;
		op_imp(8'hEA);
		op_imp(8'h02);
		op_imp(8'hFF);
		op_imp(8'h38);
		op_imp(8'hF8);
		op_imp(8'h78);
		op_imp(8'h18);
		op_imp(8'hD8);
		op_imp(8'h58);
		op_imp(8'hB8);
		op_imm(8'hA9, 8'h11);
		op_abs(8'hAD, 16'h0720);
		op_abs(8'h4C, 16'h0380);
		op_imp(8'h1A);
		run_program();
	endtask

	initial begin
		void'($urandom(32'h4c45f97e));
		rst_n_i = 1'b0;
		fill_memory();
		test_reset_jump();
		test_load_store();
		test_add_sub();
		test_logic_shift();
		test_transfer_count();
		test_cycle_count();
		if (cpu_top_i.sequencer_i.cpu_sva_i.fail_seen) begin
			abort_run("A sequencer assertion failed");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

//--- verilog.f
+incdir+include
verilog/cpu_pkg.sv
verilog/instr_decoder.sv
verilog/sequencer.sv
verilog/alu.sv
verilog/datapath.sv
verilog/cpu_top.sv
tb/cpu_sva.sv
tb/cpu_tb.sv

//--- verilog/alu.sv
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
	input  logic [7:0] a_i,
	input  logic [7:0] b_i,
	input  alu_func_e  func_i,
	input  logic       cin_i,
	output logic [7:0] y_o,
	output alu_flags_t flags_o
);

	logic [7:0] b_eff;
	logic [8:0] sum;
	logic       cout;
	logic       ovf;

	// Subtraction adds the inverted operand, so C acts as not-borrow
	assign b_eff = (func_i == ALU_SUB) ? ~b_i : b_i;
	assign sum = {1'b0, a_i} + {1'b0, b_eff} + {8'h00, cin_i};

	always_comb begin
		cout = cin_i;
		ovf = 1'b0;
		case (func_i)
		ALU_TXA: y_o = a_i;
		ALU_TXB: y_o = b_i;
		ALU_ADD, ALU_SUB: begin
			y_o = sum[7:0];
			cout = sum[8];
			ovf = (a_i[7] == b_eff[7]) && (sum[7] != a_i[7]);
		end
		ALU_INC: y_o = a_i + 8'd1;
		ALU_DEC: y_o = a_i - 8'd1;
		ALU_AND: y_o = a_i & b_i;
		ALU_ORA: y_o = a_i | b_i;
		ALU_EOR: y_o = a_i ^ b_i;
		ALU_ASL: begin
			y_o = {a_i[6:0], 1'b0};
			cout = a_i[7];
		end
		ALU_LSR: begin
			y_o = {1'b0, a_i[7:1]};
			cout = a_i[0];
		end
		ALU_ROL: begin
			y_o = {a_i[6:0], cin_i};
			cout = a_i[7];
		end
		ALU_ROR: begin
			y_o = {cin_i, a_i[7:1]};
			cout = a_i[0];
		end
		default: y_o = a_i;
		endcase

		flags_o.cout = cout;
		flags_o.sign = y_o[7];
		flags_o.zero = (y_o == 8'h00);
		flags_o.ovf = ovf;
	end

endmodule

//--- verilog/cpu_pkg.sv
package cpu_pkg;

	typedef enum logic [5:0] {
		ADC, SBC, AND, ORA, EOR,
		LDA, LDX, LDY,
		STA, STX, STY,
		ASL, LSR, ROL, ROR,
		INX, INY, DEX, DEY,
		SEC, SED, SEI, CLC, CLD, CLI, CLV,
		TAX, TAY, TSX, TXA, TXS, TYA,
		JMP,
		NOP
	} opcode_e;

	typedef enum logic [1:0] {
		Imp, Imm, Abs, Rlt
	} addr_mode_e;

	typedef enum logic [3:0] {
		ALU_TXA, ALU_TXB,
		ALU_ADD, ALU_SUB, ALU_INC, ALU_DEC,
		ALU_AND, ALU_ORA, ALU_EOR,
		ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR
	} alu_func_e;

	typedef enum logic [2:0] {
		JumpL, JumpH, Fetch, Decode, ReadH, Absolute
	} seq_state_e;

	// One-hot source of ALU operand A
	typedef struct packed {
		logic bus;
		logic acc;
		logic x;
		logic y;
		logic p;
		logic sp;
		logic dll;
		logic dlh;
		logic pcl;
		logic pch;
	} alu_bus_a_t;

	typedef struct packed {
		logic bus;
	} alu_bus_b_t;

	// Destinations of the ALU result
	typedef struct packed {
		logic bus;
		logic acc;
		logic x;
		logic y;
		logic sp;
		logic dll;
		logic dlh;
		logic pcl;
		logic pch;
	} alu_bus_o_t;

	typedef struct packed {
		logic cout;
		logic sign;
		logic zero;
		logic ovf;
	} alu_flags_t;

endpackage

//--- verilog/cpu_top.sv
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; (
	input  logic        sys,
	input  logic        rst_n_i,
	output logic [15:0] mem_addr_o,
	input  logic [7:0]  mem_rdata_i,
	output logic [7:0]  mem_wdata_o,
	output logic        mem_we_o,
	output logic        sync_o
);

	logic [7:0] ir;
	opcode_e    opcode;
	addr_mode_e mode;
	logic       bus_we, pc_addr_oe, pc_inc, pc_load, dl_addr_oe, ins_we;
	alu_bus_a_t abus_a;
	alu_bus_b_t abus_b;
	alu_bus_o_t abus_o;
	alu_func_e  alu_func;
	logic [7:0] p_mask, p_set, p_clr;

	instr_decoder decoder_i (
		.ir_i     (ir),
		.opcode_o (opcode),
		.mode_o   (mode)
	);

	sequencer sequencer_i (
		.sys          (sys),
		.rst_n_i      (rst_n_i),
		.opcode_i     (opcode),
		.mode_i       (mode),
		.bus_we_o     (bus_we),
		.sync_o       (sync_o),
		.pc_addr_oe_o (pc_addr_oe),
		.pc_inc_o     (pc_inc),
		.pc_load_o    (pc_load),
		.dl_addr_oe_o (dl_addr_oe),
		.ins_we_o     (ins_we),
		.abus_a_o     (abus_a),
		.abus_b_o     (abus_b),
		.abus_o_o     (abus_o),
		.alu_func_o   (alu_func),
		.p_mask_o     (p_mask),
		.p_set_o      (p_set),
		.p_clr_o      (p_clr)
	);

	datapath datapath_i (
		.sys          (sys),
		.rst_n_i      (rst_n_i),
		.bus_we_i     (bus_we),
		.pc_addr_oe_i (pc_addr_oe),
		.pc_inc_i     (pc_inc),
		.pc_load_i    (pc_load),
		.dl_addr_oe_i (dl_addr_oe),
		.ins_we_i     (ins_we),
		.abus_a_i     (abus_a),
		.abus_b_i     (abus_b),
		.abus_o_i     (abus_o),
		.alu_func_i   (alu_func),
		.p_mask_i     (p_mask),
		.p_set_i      (p_set),
		.p_clr_i      (p_clr),
		.mem_rdata_i  (mem_rdata_i),
		.mem_addr_o   (mem_addr_o),
		.mem_wdata_o  (mem_wdata_o),
		.ir_o         (ir),
		.p_o          ()
	);

	assign mem_we_o = bus_we;

endmodule

//--- verilog/datapath.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module datapath import cpu_pkg::*; (
	input  logic        sys,
	input  logic        rst_n_i,
	input  logic        bus_we_i,
	input  logic        pc_addr_oe_i,
	input  logic        pc_inc_i,
	input  logic        pc_load_i,
	input  logic        dl_addr_oe_i,
	input  logic        ins_we_i,
	input  alu_bus_a_t  abus_a_i,
	input  alu_bus_b_t  abus_b_i,
	input  alu_bus_o_t  abus_o_i,
	input  alu_func_e   alu_func_i,
	input  logic [7:0]  p_mask_i,
	input  logic [7:0]  p_set_i,
	input  logic [7:0]  p_clr_i,
	input  logic [7:0]  mem_rdata_i,
	output logic [15:0] mem_addr_o,
	output logic [7:0]  mem_wdata_o,
	output logic [7:0]  ir_o,
	output logic [7:0]  p_o
);

	logic [7:0]  acc_q, x_q, y_q, sp_q, p_q, ir_q;
	logic [7:0]  dll_q, dlh_q;
	logic [15:0] pc_q;
	logic [7:0]  a_op, b_op, alu_y;
	logic [7:0]  flag_vec, p_d;
	alu_flags_t  alu_flags;

	assign a_op = ({8{abus_a_i.bus}} & mem_rdata_i) |
		({8{abus_a_i.acc}} & acc_q) |
		({8{abus_a_i.x}} & x_q) |
		({8{abus_a_i.y}} & y_q) |
		({8{abus_a_i.p}} & p_q) |
		({8{abus_a_i.sp}} & sp_q) |
		({8{abus_a_i.dll}} & dll_q) |
		({8{abus_a_i.dlh}} & dlh_q) |
		({8{abus_a_i.pcl}} & pc_q[7:0]) |
		({8{abus_a_i.pch}} & pc_q[15:8]);
	assign b_op = abus_b_i.bus ? mem_rdata_i : 8'h00;

	alu alu_i (
		.a_i     (a_op),
		.b_i     (b_op),
		.func_i  (alu_func_i),
		.cin_i   (p_q[`STATUS_C]),
		.y_o     (alu_y),
		.flags_o (alu_flags)
	);

	always_comb begin
		flag_vec = 8'h00;
		flag_vec[`STATUS_C] = alu_flags.cout;
		flag_vec[`STATUS_Z] = alu_flags.zero;
		flag_vec[`STATUS_V] = alu_flags.ovf;
		flag_vec[`STATUS_N] = alu_flags.sign;
		p_d = (p_q & ~p_mask_i) | (flag_vec & p_mask_i);
		p_d = (p_d | p_set_i) & ~p_clr_i;
		p_d[`STATUS_R] = 1'b1;
		p_d[`STATUS_B] = 1'b0;
	end

	always_ff @(posedge sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			acc_q <= 8'h00;
			x_q <= 8'h00;
			y_q <= 8'h00;
			sp_q <= `SP_RESET;
			pc_q <= `RESET_VECTOR;
			ir_q <= 8'hEA;
			p_q <= 8'h00;
			p_q[`STATUS_I] <= 1'b1;
			p_q[`STATUS_R] <= 1'b1;
		end else begin
			if (abus_o_i.acc) acc_q <= alu_y;
			if (abus_o_i.x) x_q <= alu_y;
			if (abus_o_i.y) y_q <= alu_y;
			if (abus_o_i.sp) sp_q <= alu_y;
			if (ins_we_i) ir_q <= mem_rdata_i;
			p_q <= p_d;
			// Jump target is the high byte on the bus and the latched low byte
			if (pc_load_i) begin
				pc_q <= {alu_y, dll_q};
			end else if (abus_o_i.pcl || abus_o_i.pch) begin
				if (abus_o_i.pcl) pc_q[7:0] <= alu_y;
				if (abus_o_i.pch) pc_q[15:8] <= alu_y;
			end else if (pc_inc_i && pc_addr_oe_i) begin
				pc_q <= pc_q + 16'd1;
			end
		end
	end

	always_ff @(posedge sys) begin
		if (abus_o_i.dll) dll_q <= alu_y;
		if (abus_o_i.dlh) dlh_q <= alu_y;
	end

	assign mem_addr_o = dl_addr_oe_i ? {dlh_q, dll_q} : pc_q;
	assign mem_wdata_o = (bus_we_i && abus_o_i.bus) ? alu_y : 8'h00;
	assign ir_o = ir_q;
	assign p_o = p_q;

endmodule

//--- verilog/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder import cpu_pkg::*; (
	input  logic [7:0] ir_i,
	output opcode_e    opcode_o,
	output addr_mode_e mode_o
);

	always_comb begin
		case (ir_i)
		8'h69, 8'h6D: opcode_o = ADC;
		8'hE9, 8'hED: opcode_o = SBC;
		8'h29, 8'h2D: opcode_o = AND;
		8'h09, 8'h0D: opcode_o = ORA;
		8'h49, 8'h4D: opcode_o = EOR;
		8'hA9, 8'hAD: opcode_o = LDA;
		8'hA2, 8'hAE: opcode_o = LDX;
		8'hA0, 8'hAC: opcode_o = LDY;
		8'h8D: opcode_o = STA;
		8'h8E: opcode_o = STX;
		8'h8C: opcode_o = STY;
		// Accumulator shifts
		8'h0A: opcode_o = ASL;
		8'h4A: opcode_o = LSR;
		8'h2A: opcode_o = ROL;
		8'h6A: opcode_o = ROR;
		8'hE8: opcode_o = INX;
		8'hC8: opcode_o = INY;
		8'hCA: opcode_o = DEX;
		8'h88: opcode_o = DEY;
		8'h38: opcode_o = SEC;
		8'hF8: opcode_o = SED;
		8'h78: opcode_o = SEI;
		8'h18: opcode_o = CLC;
		8'hD8: opcode_o = CLD;
		8'h58: opcode_o = CLI;
		8'hB8: opcode_o = CLV;
		8'hAA: opcode_o = TAX;
		8'hA8: opcode_o = TAY;
		8'hBA: opcode_o = TSX;
		8'h8A: opcode_o = TXA;
		8'h9A: opcode_o = TXS;
		8'h98: opcode_o = TYA;
		8'h4C: opcode_o = JMP;
		default: opcode_o = NOP;
		endcase
	end

	always_comb begin
		case (ir_i)
		8'h69, 8'hE9, 8'h29, 8'h09, 8'h49, 8'hA9, 8'hA2, 8'hA0:
			mode_o = Imm;
		8'h6D, 8'hED, 8'h2D, 8'h0D, 8'h4D, 8'hAD, 8'hAE, 8'hAC,
		8'h8D, 8'h8E, 8'h8C, 8'h4C:
			mode_o = Abs;
		default:
			mode_o = Imp;
		endcase
	end

endmodule

//--- verilog/sequencer.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module sequencer import cpu_pkg::*; (
	input  logic       sys,
	input  logic       rst_n_i,
	input  opcode_e    opcode_i,
	input  addr_mode_e mode_i,
	// Memory and program counter
	output logic       bus_we_o,
	output logic       sync_o,
	output logic       pc_addr_oe_o,
	output logic       pc_inc_o,
	output logic       pc_load_o,
	output logic       dl_addr_oe_o,
	output logic       ins_we_o,
	// ALU routing
	output alu_bus_a_t abus_a_o,
	output alu_bus_b_t abus_b_o,
	output alu_bus_o_t abus_o_o,
	output alu_func_e  alu_func_o,
	// Status register
	output logic [7:0] p_mask_o,
	output logic [7:0] p_set_o,
	output logic [7:0] p_clr_o
);

	seq_state_e state_q;
	seq_state_e state_d;
	logic       execute;

	always_ff @(posedge sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= JumpL;
		end else begin
			state_q <= state_d;
		end
	end

	assign sync_o = (state_q == Fetch);

	always_comb begin
		bus_we_o = 1'b0;
		pc_addr_oe_o = 1'b0;
		pc_inc_o = 1'b0;
		pc_load_o = 1'b0;
		dl_addr_oe_o = 1'b0;
		ins_we_o = 1'b0;
		abus_a_o = '0;
		abus_a_o.bus = 1'b1;
		abus_b_o.bus = 1'b1;
		abus_o_o = '0;
		alu_func_o = ALU_TXB;
		p_mask_o = 8'h00;
		p_set_o = 8'h00;
		p_clr_o = 8'h00;
		execute = 1'b0;
		state_d = state_q;

		case (state_q)
		JumpL: begin
			pc_addr_oe_o = 1'b1;
			pc_inc_o = 1'b1;
			abus_o_o.dll = 1'b1;
			state_d = JumpH;
		end
		JumpH: begin
			pc_addr_oe_o = 1'b1;
			pc_load_o = 1'b1;
			abus_o_o.dlh = 1'b1;
			state_d = Fetch;
		end
		Fetch: begin
			pc_addr_oe_o = 1'b1;
			pc_inc_o = 1'b1;
			ins_we_o = 1'b1;
			state_d = Decode;
		end
		Decode: begin
			pc_addr_oe_o = 1'b1;
			pc_inc_o = 1'b1;
			case (mode_i)
			Imm: begin
				execute = 1'b1;
				state_d = Fetch;
			end
			Abs: begin
				abus_o_o.dll = 1'b1;
				state_d = ReadH;
			end
			// Branches are not decoded, so Rlt runs as one byte
			Imp, Rlt: begin
				pc_inc_o = 1'b0;
				execute = 1'b1;
				state_d = Fetch;
			end
			default: state_d = Fetch;
			endcase
		end
		ReadH: begin
			pc_addr_oe_o = 1'b1;
			abus_o_o.dlh = 1'b1;
			if (opcode_i == JMP) begin
				pc_load_o = 1'b1;
				state_d = Fetch;
			end else begin
				pc_inc_o = 1'b1;
				state_d = Absolute;
			end
		end
		Absolute: begin
			dl_addr_oe_o = 1'b1;
			execute = 1'b1;
			state_d = Fetch;
		end
		default: state_d = JumpL;
		endcase

		if (execute) begin
			// Operand A is memory data unless overridden
			case (opcode_i)
			ADC, SBC, AND, ORA, EOR, ASL, LSR, ROL, ROR, STA, TAX, TAY: begin
				abus_a_o.bus = 1'b0;
				abus_a_o.acc = 1'b1;
			end
			INX, DEX, STX, TXA, TXS: begin
				abus_a_o.bus = 1'b0;
				abus_a_o.x = 1'b1;
			end
			INY, DEY, STY, TYA: begin
				abus_a_o.bus = 1'b0;
				abus_a_o.y = 1'b1;
			end
			TSX: begin
				abus_a_o.bus = 1'b0;
				abus_a_o.sp = 1'b1;
			end
			default: ;
			endcase

			case (opcode_i)
			ADC: alu_func_o = ALU_ADD;
			SBC: alu_func_o = ALU_SUB;
			AND: alu_func_o = ALU_AND;
			ORA: alu_func_o = ALU_ORA;
			EOR: alu_func_o = ALU_EOR;
			ASL: alu_func_o = ALU_ASL;
			LSR: alu_func_o = ALU_LSR;
			ROL: alu_func_o = ALU_ROL;
			ROR: alu_func_o = ALU_ROR;
			INX, INY: alu_func_o = ALU_INC;
			DEX, DEY: alu_func_o = ALU_DEC;
			STA, STX, STY, TAX, TAY, TSX, TXA, TXS, TYA: alu_func_o = ALU_TXA;
			default: alu_func_o = ALU_TXB;
			endcase

			// Result destination
			case (opcode_i)
			ADC, SBC, AND, ORA, EOR, ASL, LSR, ROL, ROR, LDA, TXA, TYA:
				abus_o_o.acc = 1'b1;
			INX, DEX, LDX, TAX, TSX:
				abus_o_o.x = 1'b1;
			INY, DEY, LDY, TAY:
				abus_o_o.y = 1'b1;
			TXS:
				abus_o_o.sp = 1'b1;
			STA, STX, STY: begin
				abus_o_o.bus = 1'b1;
				bus_we_o = 1'b1;
			end
			default: ;
			endcase

			case (opcode_i)
			ADC, SBC: begin
				p_mask_o[`STATUS_C] = 1'b1;
				p_mask_o[`STATUS_V] = 1'b1;
			end
			ASL, LSR, ROL, ROR: p_mask_o[`STATUS_C] = 1'b1;
			SEC: p_set_o[`STATUS_C] = 1'b1;
			SED: p_set_o[`STATUS_D] = 1'b1;
			SEI: p_set_o[`STATUS_I] = 1'b1;
			CLC: p_clr_o[`STATUS_C] = 1'b1;
			CLD: p_clr_o[`STATUS_D] = 1'b1;
			CLI: p_clr_o[`STATUS_I] = 1'b1;
			CLV: p_clr_o[`STATUS_V] = 1'b1;
			default: ;
			endcase

			// N and Z follow every write to A, X or Y
			if (abus_o_o.acc || abus_o_o.x || abus_o_o.y) begin
				p_mask_o[`STATUS_N] = 1'b1;
				p_mask_o[`STATUS_Z] = 1'b1;
			end
		end

		// No register loads while reset is held
		if (!rst_n_i) begin
			pc_inc_o = 1'b0;
			abus_o_o = '0;
		end
	end

endmodule
